/* simmem_params.svh */
// Sizing and DRAM timing constants for the delay calculator
// Burst sizes are byte counts from 1 to 7, and wrap bursts are not modeled
// Bank capacities must be powers of two, since iids are their log2 wide
// Costs must keep the worst beat below 2**SIMMEM_DELAY_W cycles

`ifndef SIMMEM_PARAMS_SVH
`define SIMMEM_PARAMS_SVH

// Slot tables, one per direction
`define SIMMEM_NUM_SLOTS 6
`define SIMMEM_MAX_BURST_LEN 4
`define SIMMEM_BURST_LEN_W 3

// Request fields
`define SIMMEM_AXI_ADDR_W 16
`define SIMMEM_BURST_SIZE_W 3

// Address bits below the row boundary
`define SIMMEM_ROW_LEN_W 8

`define SIMMEM_TSTP_W 8
`define SIMMEM_DELAY_W 5

// Message bank capacities
`define SIMMEM_WRESP_CAP 8
`define SIMMEM_RDATA_CAP 8

// DRAM costs in cycles
`define SIMMEM_ROW_HIT_COST 4
`define SIMMEM_ACTIVATION_COST 6
`define SIMMEM_PRECHARGE_COST 5

`endif

/* simmem_pkg.sv */
// Shared types of the delay calculator
// Write and read requests share one layout but stay distinct types
// The candidate carries one-hot slot and beat selects, the issue binary ones

`include "simmem_params.svh"

package simmem_pkg;

  // Cost classes, ordered so that a plain compare ranks them
  typedef enum logic [1:0] {
    COST_CAS         = 2'd0,
    COST_ACT_CAS     = 2'd1,
    COST_PRE_ACT_CAS = 2'd2
  } cost_class_e;

  typedef struct packed {
    logic [`SIMMEM_AXI_ADDR_W-1:0]   address;
    logic [`SIMMEM_BURST_LEN_W-1:0]  burst_length;
    logic [`SIMMEM_BURST_SIZE_W-1:0] burst_size;
  } axi_req_t;

  typedef struct packed {
    logic [$clog2(`SIMMEM_WRESP_CAP)-1:0] iid;
    axi_req_t                             req;
  } wreq_t;

  typedef struct packed {
    logic [$clog2(`SIMMEM_RDATA_CAP)-1:0] iid;
    axi_req_t                             req;
  } rreq_t;

  // Best pending beat of one table
  typedef struct packed {
    logic                                              valid;
    cost_class_e                                       cost;
    logic [`SIMMEM_TSTP_W-1:0]                         tstp;
    logic [`SIMMEM_NUM_SLOTS-1:0]                      slot_oh;
    logic [`SIMMEM_MAX_BURST_LEN-1:0]                  beat_oh;
    logic [`SIMMEM_AXI_ADDR_W-`SIMMEM_ROW_LEN_W-1:0]   row;
  } beat_cand_t;

  typedef struct packed {
    logic                                    valid;
    logic [$clog2(`SIMMEM_NUM_SLOTS)-1:0]    slot;
    logic [$clog2(`SIMMEM_MAX_BURST_LEN)-1:0] beat;
  } issue_t;

  typedef struct packed {
    logic                                            open;
    logic [`SIMMEM_AXI_ADDR_W-`SIMMEM_ROW_LEN_W-1:0] row;
  } row_state_t;

endpackage

/* burst_slot_table.sv */
// Slot table for one direction of bursts
// All beats of a burst are present at acceptance; wrap bursts are not supported
// Ages are taken modulo the timestamp width, so a burst must not wait
// 2**SIMMEM_TSTP_W cycles or its priority wraps

`timescale 1ns/10ps
`include "simmem_params.svh"

module burst_slot_table #(
  parameter type         req_t    = simmem_pkg::wreq_t,
  parameter int unsigned CAPACITY = `SIMMEM_WRESP_CAP
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  req_t                          i_req,
  input  logic                          i_req_valid,
  output logic                          o_req_ready,
  input  logic [`SIMMEM_TSTP_W-1:0]     i_tstp,
  input  simmem_pkg::row_state_t        i_row,
  output simmem_pkg::beat_cand_t        o_cand,
  input  simmem_pkg::issue_t            i_issue,
  input  logic                          i_beat_done,
  output logic                          o_burst_done,
  output logic [$clog2(CAPACITY)-1:0]   o_done_iid
);
  import simmem_pkg::*;

  localparam int unsigned num_slots = `SIMMEM_NUM_SLOTS;
  localparam int unsigned max_len   = `SIMMEM_MAX_BURST_LEN;
  localparam int unsigned addr_w    = `SIMMEM_AXI_ADDR_W;
  localparam int unsigned row_w     = `SIMMEM_AXI_ADDR_W - `SIMMEM_ROW_LEN_W;
  localparam int unsigned slot_w    = $clog2(`SIMMEM_NUM_SLOTS);
  localparam int unsigned len_w     = `SIMMEM_BURST_LEN_W;
  localparam int unsigned tstp_w    = `SIMMEM_TSTP_W;

  logic [num_slots-1:0] slot_v_q, slot_v_d;
  logic [max_len-1:0]   pending_q [num_slots];
  logic [max_len-1:0]   pending_d [num_slots];
  logic [max_len-1:0]   done_q    [num_slots];
  logic [max_len-1:0]   done_d    [num_slots];

  logic [$clog2(CAPACITY)-1:0]     iid_q  [num_slots];
  logic [addr_w-1:0]               addr_q [num_slots];
  logic [`SIMMEM_BURST_SIZE_W-1:0] size_q [num_slots];
  logic [tstp_w-1:0]               tstp_q [num_slots];

  logic                 accept;
  logic [num_slots-1:0] alloc_oh;
  logic [num_slots-1:0] fin_mhot;
  logic [num_slots-1:0] fin_oh;

  function automatic cost_class_e classify(logic [addr_w-1:0] addr, row_state_t row);
    if (!row.open) begin
      return COST_ACT_CAS;
    end
    if (addr[addr_w-1 -: row_w] == row.row) begin
      return COST_CAS;
    end
    return COST_PRE_ACT_CAS;
  endfunction

  // Lowest free slot and lowest finished slot
  assign alloc_oh    = ~slot_v_q & (slot_v_q + num_slots'(1));
  assign o_req_ready = ~&slot_v_q;
  assign accept      = i_req_valid & o_req_ready;

  for (genvar s = 0; s < num_slots; s++) begin : gen_fin
    assign fin_mhot[s] = slot_v_q[s] & (&done_q[s]);
  end
  assign fin_oh       = fin_mhot & (~fin_mhot + num_slots'(1));
  assign o_burst_done = |fin_mhot;

  always_comb begin : done_iid_mux
    o_done_iid = '0;
    for (int s = 0; s < num_slots; s++) begin
      if (fin_oh[s]) begin
        o_done_iid = iid_q[s];
      end
    end
  end

  // Cheapest beat per slot, then cheapest and oldest slot
  always_comb begin : cand_sel
    logic [addr_w-1:0]  beat_addr;
    cost_class_e        beat_cost;
    logic               slot_found;
    cost_class_e        slot_cost;
    logic [max_len-1:0] slot_beat_oh;
    logic [row_w-1:0]   slot_row;
    logic [tstp_w-1:0]  slot_age;
    logic [tstp_w-1:0]  best_age;
    o_cand   = '0;
    best_age = '0;
    for (int s = 0; s < num_slots; s++) begin
      slot_found   = 1'b0;
      slot_cost    = COST_PRE_ACT_CAS;
      slot_beat_oh = '0;
      slot_row     = '0;
      slot_age     = i_tstp - tstp_q[s];
      for (int b = 0; b < max_len; b++) begin
        beat_addr = addr_q[s] + addr_w'(b) * addr_w'(size_q[s]);
        beat_cost = classify(beat_addr, i_row);
        if (slot_v_q[s] && !pending_q[s][b] && !done_q[s][b] &&
            (!slot_found || beat_cost < slot_cost)) begin
          slot_found      = 1'b1;
          slot_cost       = beat_cost;
          slot_beat_oh    = '0;
          slot_beat_oh[b] = 1'b1;
          slot_row        = beat_addr[addr_w-1 -: row_w];
        end
      end
      if (slot_found && (!o_cand.valid || slot_cost < o_cand.cost ||
          (slot_cost == o_cand.cost && slot_age > best_age))) begin
        o_cand.valid      = 1'b1;
        o_cand.cost       = slot_cost;
        o_cand.tstp       = tstp_q[s];
        o_cand.slot_oh    = '0;
        o_cand.slot_oh[s] = 1'b1;
        o_cand.beat_oh    = slot_beat_oh;
        o_cand.row        = slot_row;
        best_age          = slot_age;
      end
    end
  end

  always_comb begin : slot_next
    slot_v_d = slot_v_q & ~fin_oh;
    for (int s = 0; s < num_slots; s++) begin
      pending_d[s] = pending_q[s];
      done_d[s]    = done_q[s];
      // Only one beat is in flight, so the done pulse retires all pending bits
      if (i_beat_done) begin
        done_d[s]    = done_q[s] | pending_q[s];
        pending_d[s] = '0;
      end
      if (i_issue.valid && i_issue.slot == slot_w'(s)) begin
        pending_d[s][i_issue.beat] = 1'b1;
      end
      if (accept && alloc_oh[s]) begin
        slot_v_d[s]  = 1'b1;
        pending_d[s] = '0;
        // Beats past the burst length never go to the DRAM
        for (int b = 0; b < max_len; b++) begin
          done_d[s][b] = len_w'(b) >= i_req.req.burst_length;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_v_q  <= '0;
      pending_q <= '{default: '0};
      done_q    <= '{default: '0};
    end else begin
      slot_v_q  <= slot_v_d;
      pending_q <= pending_d;
      done_q    <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int s = 0; s < num_slots; s++) begin
      if (accept && alloc_oh[s]) begin
        iid_q[s]  <= i_req.iid;
        addr_q[s] <= i_req.req.address;
        size_q[s] <= i_req.req.burst_size;
        tstp_q[s] <= i_tstp;
      end
    end
  end

endmodule

/* rank_scheduler.sv */
// Single-rank DRAM model serving one beat at a time
// The counter holds the remaining cycles minus one, so a new beat issues
// on the same edge where the previous one finishes
// Writes win a full tie with reads

`timescale 1ns/10ps
`include "simmem_params.svh"

module rank_scheduler (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  simmem_pkg::beat_cand_t    i_wcand,
  input  simmem_pkg::beat_cand_t    i_rcand,
  output simmem_pkg::issue_t        o_wissue,
  output simmem_pkg::issue_t        o_rissue,
  output logic                      o_wbeat_done,
  output logic                      o_rbeat_done,
  output simmem_pkg::row_state_t    o_row,
  output logic [`SIMMEM_TSTP_W-1:0] o_tstp
);
  import simmem_pkg::*;

  localparam int unsigned delay_w   = `SIMMEM_DELAY_W;
  localparam int unsigned tstp_w    = `SIMMEM_TSTP_W;
  localparam int unsigned num_slots = `SIMMEM_NUM_SLOTS;
  localparam int unsigned max_len   = `SIMMEM_MAX_BURST_LEN;
  localparam int unsigned slot_w    = $clog2(`SIMMEM_NUM_SLOTS);
  localparam int unsigned beat_w    = $clog2(`SIMMEM_MAX_BURST_LEN);

  logic [delay_w-1:0] cnt_q, cnt_d;
  logic               busy_q, busy_d;
  logic               side_w_q, side_w_d;
  row_state_t         row_q, row_d;
  logic [tstp_w-1:0]  tstp_q;

  logic               issue_en;
  logic               serve_w;
  logic               serve_r;
  logic [tstp_w-1:0]  w_age;
  logic [tstp_w-1:0]  r_age;
  beat_cand_t         win;

  function automatic logic [delay_w-1:0] decompress(cost_class_e cost);
    case (cost)
      COST_CAS:     return delay_w'(`SIMMEM_ROW_HIT_COST);
      COST_ACT_CAS: return delay_w'(`SIMMEM_ROW_HIT_COST + `SIMMEM_ACTIVATION_COST);
      default: begin
        return delay_w'(`SIMMEM_ROW_HIT_COST + `SIMMEM_ACTIVATION_COST +
                        `SIMMEM_PRECHARGE_COST);
      end
    endcase
  endfunction

  function automatic logic [slot_w-1:0] slot_index(logic [num_slots-1:0] onehot);
    logic [slot_w-1:0] idx;
    idx = '0;
    for (int i = 0; i < num_slots; i++) begin
      if (onehot[i]) begin
        idx = slot_w'(i);
      end
    end
    return idx;
  endfunction

  function automatic logic [beat_w-1:0] beat_index(logic [max_len-1:0] onehot);
    logic [beat_w-1:0] idx;
    idx = '0;
    for (int i = 0; i < max_len; i++) begin
      if (onehot[i]) begin
        idx = beat_w'(i);
      end
    end
    return idx;
  endfunction

  // Ages relative to now, so timestamp wrap does not flip the order
  assign w_age = tstp_q - i_wcand.tstp;
  assign r_age = tstp_q - i_rcand.tstp;

  assign issue_en = cnt_q == '0;
  assign serve_w  = issue_en && i_wcand.valid &&
                    (!i_rcand.valid || i_wcand.cost < i_rcand.cost ||
                     (i_wcand.cost == i_rcand.cost && w_age >= r_age));
  assign serve_r  = issue_en && i_rcand.valid && !serve_w;
  assign win      = serve_w ? i_wcand : i_rcand;

  assign o_wissue = '{valid: serve_w, slot: slot_index(i_wcand.slot_oh),
                      beat: beat_index(i_wcand.beat_oh)};
  assign o_rissue = '{valid: serve_r, slot: slot_index(i_rcand.slot_oh),
                      beat: beat_index(i_rcand.beat_oh)};

  // Last cycle of the beat in flight
  assign o_wbeat_done = busy_q && issue_en && side_w_q;
  assign o_rbeat_done = busy_q && issue_en && !side_w_q;

  assign o_row  = row_q;
  assign o_tstp = tstp_q;

  always_comb begin : rank_next
    cnt_d    = cnt_q;
    busy_d   = busy_q;
    side_w_d = side_w_q;
    row_d    = row_q;
    if (!issue_en) begin
      cnt_d = cnt_q - delay_w'(1);
    end else if (serve_w || serve_r) begin
      cnt_d    = decompress(win.cost) - delay_w'(1);
      busy_d   = 1'b1;
      side_w_d = serve_w;
      row_d    = '{open: 1'b1, row: win.row};
    end else begin
      busy_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= '0;
      busy_q   <= 1'b0;
      side_w_q <= 1'b0;
      row_q    <= '0;
      tstp_q   <= '0;
    end else begin
      cnt_q    <= cnt_d;
      busy_q   <= busy_d;
      side_w_q <= side_w_d;
      row_q    <= row_d;
      tstp_q   <= tstp_q + tstp_w'(1);
    end
  end

endmodule

/* release_tracker.sv */
// One-hot release enables toward a message bank
// A completion and a release on the same bit in one cycle leave it set

`timescale 1ns/10ps

module release_tracker #(
  parameter int unsigned CAPACITY = 8
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        i_set,
  input  logic [$clog2(CAPACITY)-1:0] i_set_iid,
  input  logic [CAPACITY-1:0]         i_released_onehot,
  output logic [CAPACITY-1:0]         o_release_en_onehot
);

  logic [CAPACITY-1:0] set_onehot;
  logic [CAPACITY-1:0] release_en_d;

  // Decode of the finished burst iid
  assign set_onehot = CAPACITY'(i_set) << i_set_iid;

  // Clear on release, then set on completion
  assign release_en_d = (o_release_en_onehot & ~i_released_onehot) | set_onehot;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      o_release_en_onehot <= '0;
    end else begin
      o_release_en_onehot <= release_en_d;
    end
  end

endmodule

/* simmem_delay_calc.sv */
// Memory timing delay calculator for a simulated AXI memory
// Write data is assumed complete when its address is accepted
// Iids must be unique among bursts in flight on each side
// Released inputs are single-cycle pulses from the banks

`timescale 1ns/10ps
`include "simmem_params.svh"

module simmem_delay_calc (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  input  simmem_pkg::wreq_t            i_waddr_req,
  input  logic                         i_waddr_valid,
  output logic                         o_waddr_ready,

  input  simmem_pkg::rreq_t            i_raddr_req,
  input  logic                         i_raddr_valid,
  output logic                         o_raddr_ready,

  output logic [`SIMMEM_WRESP_CAP-1:0] o_wresp_release_en_onehot,
  output logic [`SIMMEM_RDATA_CAP-1:0] o_rdata_release_en_onehot,
  input  logic [`SIMMEM_WRESP_CAP-1:0] i_wresp_released_onehot,
  input  logic [`SIMMEM_RDATA_CAP-1:0] i_rdata_released_onehot
);
  import simmem_pkg::*;

  localparam int unsigned wiid_w = $clog2(`SIMMEM_WRESP_CAP);
  localparam int unsigned riid_w = $clog2(`SIMMEM_RDATA_CAP);

  beat_cand_t                wcand;
  beat_cand_t                rcand;
  issue_t                    wissue;
  issue_t                    rissue;
  logic                      wbeat_done;
  logic                      rbeat_done;
  row_state_t                row;
  logic [`SIMMEM_TSTP_W-1:0] tstp;

  logic                      wburst_done;
  logic                      rburst_done;
  logic [wiid_w-1:0]         wdone_iid;
  logic [riid_w-1:0]         rdone_iid;

  burst_slot_table #(
    .req_t   (wreq_t),
    .CAPACITY(`SIMMEM_WRESP_CAP)
  ) u_wslots (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .i_req       (i_waddr_req),
    .i_req_valid (i_waddr_valid),
    .o_req_ready (o_waddr_ready),
    .i_tstp      (tstp),
    .i_row       (row),
    .o_cand      (wcand),
    .i_issue     (wissue),
    .i_beat_done (wbeat_done),
    .o_burst_done(wburst_done),
    .o_done_iid  (wdone_iid)
  );

  burst_slot_table #(
    .req_t   (rreq_t),
    .CAPACITY(`SIMMEM_RDATA_CAP)
  ) u_rslots (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .i_req       (i_raddr_req),
    .i_req_valid (i_raddr_valid),
    .o_req_ready (o_raddr_ready),
    .i_tstp      (tstp),
    .i_row       (row),
    .o_cand      (rcand),
    .i_issue     (rissue),
    .i_beat_done (rbeat_done),
    .o_burst_done(rburst_done),
    .o_done_iid  (rdone_iid)
  );

  rank_scheduler u_sched (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .i_wcand     (wcand),
    .i_rcand     (rcand),
    .o_wissue    (wissue),
    .o_rissue    (rissue),
    .o_wbeat_done(wbeat_done),
    .o_rbeat_done(rbeat_done),
    .o_row       (row),
    .o_tstp      (tstp)
  );

  release_tracker #(.CAPACITY(`SIMMEM_WRESP_CAP)) u_wrel (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .i_set              (wburst_done),
    .i_set_iid          (wdone_iid),
    .i_released_onehot  (i_wresp_released_onehot),
    .o_release_en_onehot(o_wresp_release_en_onehot)
  );

  release_tracker #(.CAPACITY(`SIMMEM_RDATA_CAP)) u_rrel (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .i_set              (rburst_done),
    .i_set_iid          (rdone_iid),
    .i_released_onehot  (i_rdata_released_onehot),
    .o_release_en_onehot(o_rdata_release_en_onehot)
  );

endmodule

/* tb_simmem_delay_calc.sv */
// Testbench for the memory timing delay calculator
// Directed latency, cost ordering, back-pressure and release checks, then random traffic
// The reference cost model tracks the open row only through the directed tests
// Runs are bounded by a global cycle limit

`timescale 1ns/10ps
`include "simmem_params.svh"

module tb_simmem_delay_calc;
  import simmem_pkg::*;

  localparam int unsigned cycle_limit = 4000;
  localparam int unsigned num_random  = 30;

  logic        clk_i;
  logic        rst_ni;
  wreq_t       i_waddr_req;
  logic        i_waddr_valid;
  logic        o_waddr_ready;
  rreq_t       i_raddr_req;
  logic        i_raddr_valid;
  logic        o_raddr_ready;
  logic [7:0]  o_wresp_release_en_onehot;
  logic [7:0]  o_rdata_release_en_onehot;
  logic [7:0]  i_wresp_released_onehot;
  logic [7:0]  i_rdata_released_onehot;

  int          cycles;
  int          val_errs;
  int          proto_errs;
  int          accepts;
  int          rises;
  logic [31:0] rng;
  logic [7:0]  w_inflight;
  logic [7:0]  r_inflight;
  logic [7:0]  w_prev;
  logic [7:0]  r_prev;
  logic        model_open;
  logic [7:0]  model_row;

  simmem_delay_calc simmem_delay_calc_i (.*);

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    w_prev <= o_wresp_release_en_onehot;
    r_prev <= o_rdata_release_en_onehot;
    if (rst_ni) begin
      rises <= rises + $countones(o_wresp_release_en_onehot & ~w_prev) +
               $countones(o_rdata_release_en_onehot & ~r_prev);
    end
    if (cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // A release bit may only rise for a burst that was accepted and not yet released
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((o_wresp_release_en_onehot & ~$past(o_wresp_release_en_onehot)) & ~w_inflight) == '0)
  else begin
    val_errs++;
    $display("Fail %0t: write release bit rose without a burst in flight", $time);
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((o_rdata_release_en_onehot & ~$past(o_rdata_release_en_onehot)) & ~r_inflight) == '0)
  else begin
    val_errs++;
    $display("Fail %0t: read release bit rose without a burst in flight", $time);
  end

  // Released pulse clears its bit on the next edge
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (o_wresp_release_en_onehot & $past(i_wresp_released_onehot)) == '0)
  else begin
    val_errs++;
    $display("Fail %0t: write release bit not cleared by its pulse", $time);
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (o_rdata_release_en_onehot & $past(i_rdata_released_onehot)) == '0)
  else begin
    val_errs++;
    $display("Fail %0t: read release bit not cleared by its pulse", $time);
  end

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Reference DRAM cost of one burst, following the open row
  function automatic int burst_cost(logic [15:0] addr, int len, int size);
    int          total;
    logic [15:0] a;
    total = 0;
    for (int b = 0; b < len; b++) begin
      a = addr + 16'(b * size);
      if (!model_open) begin
        total += `SIMMEM_ROW_HIT_COST + `SIMMEM_ACTIVATION_COST;
      end else if (a[15:8] == model_row) begin
        total += `SIMMEM_ROW_HIT_COST;
      end else begin
        total += `SIMMEM_ROW_HIT_COST + `SIMMEM_ACTIVATION_COST + `SIMMEM_PRECHARGE_COST;
      end
      model_open = 1'b1;
      model_row  = a[15:8];
    end
    return total;
  endfunction

  // Called 2 ns after an edge, returns 2 ns after the acceptance edge
  task automatic send_req(input bit is_read, input int iid, input logic [15:0] addr,
                          input int len, input int size, output int acc);
    if (is_read) begin
      i_raddr_req.iid              = 3'(iid);
      i_raddr_req.req.address      = addr;
      i_raddr_req.req.burst_length = 3'(len);
      i_raddr_req.req.burst_size   = 3'(size);
      i_raddr_valid                = 1'b1;
      while (!o_raddr_ready) begin
        @(posedge clk_i);
        #2;
      end
    end else begin
      i_waddr_req.iid              = 3'(iid);
      i_waddr_req.req.address      = addr;
      i_waddr_req.req.burst_length = 3'(len);
      i_waddr_req.req.burst_size   = 3'(size);
      i_waddr_valid                = 1'b1;
      while (!o_waddr_ready) begin
        @(posedge clk_i);
        #2;
      end
    end
    @(posedge clk_i);
    #2;
    acc = cycles;
    i_raddr_valid = 1'b0;
    i_waddr_valid = 1'b0;
    accepts++;
    if (is_read) begin
      r_inflight[iid] = 1'b1;
    end else begin
      w_inflight[iid] = 1'b1;
    end
  endtask

  task automatic wait_release(input bit is_read, input int iid);
    while (!(is_read ? o_rdata_release_en_onehot[iid] : o_wresp_release_en_onehot[iid])) begin
      @(posedge clk_i);
      #2;
    end
  endtask

  // One-cycle released pulse; optionally checks that no other bit moved
  task automatic pulse_release(input bit is_read, input logic [7:0] mask, input bit check);
    logic [7:0] old_bits;
    old_bits = is_read ? o_rdata_release_en_onehot : o_wresp_release_en_onehot;
    if (is_read) begin
      i_rdata_released_onehot = mask;
    end else begin
      i_wresp_released_onehot = mask;
    end
    @(posedge clk_i);
    #2;
    i_rdata_released_onehot = '0;
    i_wresp_released_onehot = '0;
    if (check) begin
      assert ((is_read ? o_rdata_release_en_onehot : o_wresp_release_en_onehot) ==
              (old_bits & ~mask))
      else begin
        val_errs++;
        $display("Fail %0t: release pulse %h changed other bits", $time, mask);
      end
    end
    if (is_read) begin
      r_inflight = r_inflight & ~mask;
    end else begin
      w_inflight = w_inflight & ~mask;
    end
  endtask

  task automatic check_latency(input bit is_read, input int iid, input int acc, input int exp);
    wait_release(is_read, iid);
    assert (cycles - acc == exp)
    else begin
      val_errs++;
      $display("Fail %0t: iid %0d released after %0d edges, expected %0d",
               $time, iid, cycles - acc, exp);
    end
  endtask

  initial begin
    int acc;
    int iid;
    bit is_read;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    i_waddr_req = '0;
    i_raddr_req = '0;
    i_waddr_valid = 1'b0;
    i_raddr_valid = 1'b0;
    i_wresp_released_onehot = '0;
    i_rdata_released_onehot = '0;
    cycles = 0;
    val_errs = 0;
    proto_errs = 0;
    accepts = 0;
    rises = 0;
    rng = 32'h27ec_7f48;
    w_inflight = '0;
    r_inflight = '0;
    model_open = 1'b0;
    model_row = '0;
    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // Reset state
    assert (o_waddr_ready && o_raddr_ready && o_wresp_release_en_onehot == '0 &&
            o_rdata_release_en_onehot == '0)
    else begin
      val_errs++;
      $display("Fail %0t: wrong state after reset", $time);
    end

    // Lone write into a closed row, then a read to another row
    send_req(1'b0, 0, 16'h1000, 3, 4, acc);
    check_latency(1'b0, 0, acc, burst_cost(16'h1000, 3, 4) + 2);
    send_req(1'b1, 0, 16'h2000, 1, 4, acc);
    check_latency(1'b1, 0, acc, burst_cost(16'h2000, 1, 4) + 2);
    pulse_release(1'b0, 8'h01, 1'b1);
    pulse_release(1'b1, 8'h01, 1'b1);

    // Younger row-hit read overtakes an older write to another row
    send_req(1'b0, 2, 16'h2000, 4, 4, acc);
    send_req(1'b0, 1, 16'h3000, 1, 4, acc);
    send_req(1'b1, 1, 16'h2040, 1, 4, acc);
    while (!o_rdata_release_en_onehot[1] && !o_wresp_release_en_onehot[1]) begin
      @(posedge clk_i);
      #2;
    end
    assert (o_rdata_release_en_onehot[1] && !o_wresp_release_en_onehot[1])
    else begin
      val_errs++;
      $display("Fail %0t: older write to another row released before row-hit read", $time);
    end
    wait_release(1'b0, 1);
    wait_release(1'b0, 2);
    pulse_release(1'b0, 8'h06, 1'b1);
    pulse_release(1'b1, 8'h02, 1'b1);

    // Back-pressure with all six write slots taken
    for (int k = 0; k < 6; k++) begin
      send_req(1'b0, k, 16'h3000 + 16'(k * 16), 4, 4, acc);
    end
    assert (!o_waddr_ready)
    else begin
      proto_errs++;
      $display("Write ready stayed high with all six slots occupied");
    end
    send_req(1'b0, 6, 16'h3100, 1, 4, acc);
    assert (o_wresp_release_en_onehot != '0)
    else begin
      proto_errs++;
      $display("Seventh write was accepted before any slot was freed");
    end
    for (int k = 0; k < 7; k++) begin
      wait_release(1'b0, k);
    end
    pulse_release(1'b0, 8'h7f, 1'b1);

    // Random mixed traffic with unique in-flight iids
    for (int n = 0; n < num_random; n++) begin
      if (o_wresp_release_en_onehot != '0) begin
        pulse_release(1'b0, o_wresp_release_en_onehot, 1'b0);
      end
      if (o_rdata_release_en_onehot != '0) begin
        pulse_release(1'b1, o_rdata_release_en_onehot, 1'b0);
      end
      rng = xorshift(rng);
      is_read = rng[31];
      iid = -1;
      for (int k = 0; k < 8; k++) begin
        if (iid < 0 && !(is_read ? r_inflight[(rng[2:0] + k) % 8] :
                                   w_inflight[(rng[2:0] + k) % 8])) begin
          iid = (rng[2:0] + k) % 8;
        end
      end
      if (iid >= 0) begin
        send_req(is_read, iid, rng[23:8], int'(rng[25:24]) + 1, int'(rng[28:26] % 7) + 1, acc);
      end
    end
    // Drain everything still in flight
    while (w_inflight != '0 || r_inflight != '0) begin
      if (o_wresp_release_en_onehot != '0) begin
        pulse_release(1'b0, o_wresp_release_en_onehot, 1'b0);
      end else if (o_rdata_release_en_onehot != '0) begin
        pulse_release(1'b1, o_rdata_release_en_onehot, 1'b0);
      end else begin
        @(posedge clk_i);
        #2;
      end
    end
    repeat (2) @(posedge clk_i);
    assert (rises == accepts)
    else begin
      val_errs++;
      $display("Fail %0t: %0d release rises for %0d accepted bursts", $time, rises, accepts);
    end

    $display("Done: %0d value errors, %0d protocol errors", val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+.
simmem_pkg.sv
burst_slot_table.sv
rank_scheduler.sv
release_tracker.sv
simmem_delay_calc.sv
tb_simmem_delay_calc.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_simmem_delay_calc
FILELIST  ?= vlog.f

OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
SRCS    := $(filter-out +incdir+%,$(shell cat $(FILELIST))) simmem_params.svh
PASS    := *** TEST PASSED ***

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS)"

clean:
	rm -rf $(OBJ_DIR)
